// File: src/videoTxPkg.sv
//--------------------------------------------------------------------------
// Video transmit package
// Channel count, sample widths, CSR map and status bit positions
//--------------------------------------------------------------------------
package videoTxPkg;

	// Colour lanes R, G, B
	localparam int cChannels   = 3;

	// Memory word, RGB565
	localparam int cPixelBits  = 16;

	// Expanded and panel channel depths
	localparam int cSampleBits = 8;
	localparam int cOutBits    = 4;

	typedef logic [cSampleBits-1:0] tSample;
	typedef logic [cOutBits-1:0]    tOut;

	// CSR byte offsets
	localparam int cCtrlAdrs   = 'h0;
	localparam int cFbufAdrs   = 'h4;
	localparam int cStatusAdrs = 'h8;

	// CTRL and STATUS bits
	localparam int cCtrlDisplayEn = 0;
	localparam int cCtrlDmaEn     = 1;
	localparam int cStatUnderflow = 0;
	localparam int cStatFrameLsb  = 8;

endpackage

// File: src/videoTxCsr.sv
//--------------------------------------------------------------------------
// Video transmit register slave
// CTRL enables, frame buffer base address and STATUS with sticky
// underflow and a wrapping frame count
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module videoTxCsr
	import videoTxPkg::*;
#(
	parameter int pBusAdrsBit   = 16,
	parameter int pMemAdrsWidth = 19
)(
	input  logic                     sysClk,
	input  logic                     rstN,
	// Register bus
	input  logic [pBusAdrsBit-1:0]   csrAdrs,
	input  logic [31:0]              csrWd,
	input  logic                     csrWe,
	input  logic                     csrRe,
	output logic [31:0]              csrRd,
	output logic                     csrRdValid,
	// Control out
	output logic                     displayEn,
	output logic                     dmaEn,
	output logic [pMemAdrsWidth-1:0] fbufAdrs,
	// Status in
	input  logic [cChannels-1:0]     underrun,
	input  logic                     frameStart
);

localparam int cFrameBits = 8;

logic                  selCtrl;
logic                  selFbuf;
logic                  selStatus;
logic                  underflow;
logic [cFrameBits-1:0] frameCount;
logic [31:0]           rdMux;

assign selCtrl   = csrAdrs == pBusAdrsBit'(cCtrlAdrs);
assign selFbuf   = csrAdrs == pBusAdrsBit'(cFbufAdrs);
assign selStatus = csrAdrs == pBusAdrsBit'(cStatusAdrs);

//--------------------------------------------------------------------------
// Register write
//--------------------------------------------------------------------------
always_ff @(posedge sysClk or negedge rstN)
begin
	if (!rstN)
	begin
		displayEn  <= 1'b0;
		dmaEn      <= 1'b0;
		fbufAdrs   <= '0;
		underflow  <= 1'b0;
		frameCount <= '0;
	end
	else
	begin
		if (csrWe && selCtrl)
		begin
			displayEn <= csrWd[cCtrlDisplayEn];
			dmaEn     <= csrWd[cCtrlDmaEn];
		end
		if (csrWe && selFbuf)
			fbufAdrs <= csrWd[pMemAdrsWidth-1:0];

		// A new underrun wins over a clear in the same cycle
		if (|underrun)
			underflow <= 1'b1;
		else if (csrWe && selStatus && csrWd[cStatUnderflow])
			underflow <= 1'b0;

		if (frameStart)
			frameCount <= frameCount + 1'b1;
	end
end

//--------------------------------------------------------------------------
// Read path, data one cycle after the strobe
//--------------------------------------------------------------------------
always_comb
begin
	rdMux = '0;
	if (selCtrl)
	begin
		rdMux[cCtrlDisplayEn] = displayEn;
		rdMux[cCtrlDmaEn]     = dmaEn;
	end
	else if (selFbuf)
		rdMux[pMemAdrsWidth-1:0] = fbufAdrs;
	else if (selStatus)
	begin
		rdMux[cStatUnderflow]            = underflow;
		rdMux[cStatFrameLsb +: cFrameBits] = frameCount;
	end
end

always_ff @(posedge sysClk or negedge rstN)
begin
	if (!rstN)
		csrRdValid <= 1'b0;
	else
		csrRdValid <= csrRe;
end

always_ff @(posedge sysClk)
begin
	if (csrRe)
		csrRd <= rdMux;
end

endmodule

// File: src/frameFetcher.sv
//--------------------------------------------------------------------------
// Frame fetcher
// Reads one frame of RGB565 words per frame start, expands each pixel
// to three 8-bit samples and spends one credit per lane per request
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module frameFetcher
	import videoTxPkg::*;
#(
	parameter int pHdisplay     = 480,
	parameter int pVdisplay     = 272,
	parameter int pMemAdrsWidth = 19,
	parameter int pLaneDepth    = 8
)(
	input  logic                     sysClk,
	input  logic                     rstN,
	input  logic                     dmaEn,
	input  logic                     frameStart,
	input  logic [pMemAdrsWidth-1:0] fbufAdrs,
	// Memory read bus
	output logic [pMemAdrsWidth-1:0] memAdrs,
	output logic                     memReq,
	input  logic                     memRdy,
	input  logic [cPixelBits-1:0]    memRd,
	input  logic                     memRdValid,
	// Lanes
	output tSample                   laneData [cChannels],
	output logic                     laneValid,
	input  logic [cChannels-1:0]     credit
);

localparam int cPixels  = pHdisplay * pVdisplay;
localparam int cRemainW = $clog2(cPixels + 1);
localparam int cCreditW = $clog2(pLaneDepth + 1);

logic [pMemAdrsWidth-1:0] adrsCnt;
logic [cRemainW-1:0]      remain;
logic [cCreditW-1:0]      creditCnt [cChannels];
logic                     allCredit;
logic                     reqHold;
logic                     startPend;
logic                     reload;
logic                     accept;

always_comb
begin
	allCredit = 1'b1;
	for (int i = 0; i < cChannels; i++)
	begin
		if (creditCnt[i] == '0)
			allCredit = 1'b0;
	end
end

// A stalled request stays up whatever dmaEn or frameStart do
assign memReq  = reqHold
	|| (dmaEn && remain != '0 && allCredit && !frameStart && !startPend);
assign memAdrs = adrsCnt;
assign accept  = memReq && memRdy;

// Base reload waits until no request is stalled
assign reload  = (frameStart || startPend) && !reqHold;

//--------------------------------------------------------------------------
// Address and pixel counters
//--------------------------------------------------------------------------
always_ff @(posedge sysClk or negedge rstN)
begin
	if (!rstN)
	begin
		adrsCnt   <= '0;
		remain    <= '0;
		reqHold   <= 1'b0;
		startPend <= 1'b0;
	end
	else
	begin
		reqHold   <= memReq && !memRdy;
		startPend <= (frameStart || startPend) && reqHold;
		if (reload)
		begin
			adrsCnt <= fbufAdrs;
			remain  <= cRemainW'(cPixels);
		end
		else if (accept)
		begin
			adrsCnt <= adrsCnt + 1'b1;
			remain  <= remain - 1'b1;
		end
	end
end

//--------------------------------------------------------------------------
// Lane credits
//--------------------------------------------------------------------------
always_ff @(posedge sysClk or negedge rstN)
begin
	if (!rstN)
	begin
		for (int i = 0; i < cChannels; i++)
			creditCnt[i] <= cCreditW'(pLaneDepth);
	end
	else
	begin
		for (int i = 0; i < cChannels; i++)
			creditCnt[i] <= creditCnt[i] - cCreditW'(accept) + cCreditW'(credit[i]);
	end
end

//--------------------------------------------------------------------------
// Pixel expansion by bit replication
//--------------------------------------------------------------------------
always_ff @(posedge sysClk or negedge rstN)
begin
	if (!rstN)
		laneValid <= 1'b0;
	else
		laneValid <= memRdValid;
end

always_ff @(posedge sysClk)
begin
	if (memRdValid)
	begin
		// R5, G6, B5 from the top down
		laneData[0] <= {memRd[15:11], memRd[15:13]};
		laneData[1] <= {memRd[10:5], memRd[10:9]};
		laneData[2] <= {memRd[4:0], memRd[4:2]};
	end
end

endmodule

// File: src/colorLane.sv
//--------------------------------------------------------------------------
// Colour lane
// Sample FIFO with credit return and per-line error diffusion from
// 8-bit samples down to the 4-bit panel depth
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module colorLane
	import videoTxPkg::*;
#(
	parameter int pLaneDepth = 8
)(
	input  logic   sysClk,
	input  logic   rstN,
	input  tSample pushData,
	input  logic   push,
	input  logic   pop,
	input  logic   lineStart,
	output logic   credit,
	output tOut    outValue,
	output logic   underrun
);

localparam int cPtrW = (pLaneDepth > 1) ? $clog2(pLaneDepth) : 1;
localparam int cCntW = $clog2(pLaneDepth + 1);

tSample               fifoMem [pLaneDepth];
logic [cPtrW-1:0]     wrPtr;
logic [cPtrW-1:0]     rdPtr;
logic [cCntW-1:0]     fill;
logic                 empty;
logic                 doPop;
logic [cOutBits-1:0]  residual;
logic [cOutBits-1:0]  carryIn;
logic [cSampleBits:0] sum;

assign empty   = fill == '0;
assign doPop   = pop && !empty;

// Residual restarts at each line
assign carryIn = lineStart ? '0 : residual;
assign sum     = (cSampleBits + 1)'(fifoMem[rdPtr]) + (cSampleBits + 1)'(carryIn);

always_ff @(posedge sysClk)
begin
	if (push)
		fifoMem[wrPtr] <= pushData;
end

always_ff @(posedge sysClk or negedge rstN)
begin
	if (!rstN)
	begin
		wrPtr    <= '0;
		rdPtr    <= '0;
		fill     <= '0;
		residual <= '0;
		outValue <= '0;
		credit   <= 1'b0;
		underrun <= 1'b0;
	end
	else
	begin
		if (push)
			wrPtr <= (wrPtr == cPtrW'(pLaneDepth - 1)) ? '0 : wrPtr + 1'b1;
		if (doPop)
			rdPtr <= (rdPtr == cPtrW'(pLaneDepth - 1)) ? '0 : rdPtr + 1'b1;
		fill     <= fill + cCntW'(push) - cCntW'(doPop);
		credit   <= doPop;
		underrun <= pop && empty;

		if (pop)
		begin
			if (empty)
			begin
				outValue <= '0;
				residual <= '0;
			end
			else if (sum[cSampleBits])
			begin
				// Saturate
				outValue <= '1;
				residual <= '0;
			end
			else
			begin
				outValue <= sum[cSampleBits-1 -: cOutBits];
				residual <= sum[cOutBits-1:0];
			end
		end
	end
end

endmodule

// File: src/tftTiming.sv
//--------------------------------------------------------------------------
// TFT timing generator
// Horizontal and vertical counters, registered syncs and data enable,
// lane pop and line and frame markers
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module tftTiming #(
	parameter int pHdisplay = 480,
	parameter int pHfront   = 8,
	parameter int pHpulse   = 10,
	parameter int pHback    = 43,
	parameter int pVdisplay = 272,
	parameter int pVfront   = 12,
	parameter int pVpulse   = 10,
	parameter int pVback    = 4
)(
	input  logic sysClk,
	input  logic rstN,
	input  logic displayEn,
	output logic pop,
	output logic lineStart,
	output logic frameStart,
	output logic tftHSync,
	output logic tftVSync,
	output logic tftDe
);

// Line is sync, back porch, active, front porch
localparam int cHStart = pHpulse + pHback;
localparam int cHEnd   = cHStart + pHdisplay;
localparam int cHTotal = cHEnd + pHfront;
localparam int cVStart = pVpulse + pVback;
localparam int cVEnd   = cVStart + pVdisplay;
localparam int cVTotal = cVEnd + pVfront;
localparam int cHW     = $clog2(cHTotal + 1);
localparam int cVW     = $clog2(cVTotal + 1);

logic [cHW-1:0] hCnt;
logic [cVW-1:0] vCnt;
logic           hActive;
logic           vActive;
logic           active;
logic           hSyncOn;
logic           vSyncOn;

//--------------------------------------------------------------------------
// Counters, held at the origin while the display is off
//--------------------------------------------------------------------------
always_ff @(posedge sysClk or negedge rstN)
begin
	if (!rstN)
	begin
		hCnt <= '0;
		vCnt <= '0;
	end
	else if (!displayEn)
	begin
		hCnt <= '0;
		vCnt <= '0;
	end
	else if (hCnt == cHW'(cHTotal - 1))
	begin
		hCnt <= '0;
		vCnt <= (vCnt == cVW'(cVTotal - 1)) ? '0 : vCnt + 1'b1;
	end
	else
		hCnt <= hCnt + 1'b1;
end

//--------------------------------------------------------------------------
// Decode
//--------------------------------------------------------------------------
assign hActive    = hCnt >= cHW'(cHStart) && hCnt < cHW'(cHEnd);
assign vActive    = vCnt >= cVW'(cVStart) && vCnt < cVW'(cVEnd);
assign active     = displayEn && hActive && vActive;
assign hSyncOn    = displayEn && hCnt < cHW'(pHpulse);
assign vSyncOn    = displayEn && vCnt < cVW'(pVpulse);

assign pop        = active;
assign lineStart  = active && hCnt == cHW'(cHStart);
assign frameStart = displayEn && hCnt == '0 && vCnt == '0;

// Panel controls, same cycle as the lane outputs
always_ff @(posedge sysClk or negedge rstN)
begin
	if (!rstN)
	begin
		tftHSync <= 1'b1;
		tftVSync <= 1'b1;
		tftDe    <= 1'b0;
	end
	else
	begin
		tftHSync <= !hSyncOn;
		tftVSync <= !vSyncOn;
		tftDe    <= active;
	end
end

endmodule

// File: src/videoTxTop.sv
//--------------------------------------------------------------------------
// Video transmit top level
// Register slave, frame fetcher, three colour lanes and TFT timing
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module videoTxTop
	import videoTxPkg::*;
#(
	parameter int pHdisplay     = 480,
	parameter int pHfront       = 8,
	parameter int pHpulse       = 10,
	parameter int pHback        = 43,
	parameter int pVdisplay     = 272,
	parameter int pVfront       = 12,
	parameter int pVpulse       = 10,
	parameter int pVback        = 4,
	parameter int pMemAdrsWidth = 19,
	parameter int pLaneDepth    = 8,
	parameter int pBusAdrsBit   = 16
)(
	input  logic                     sysClk,
	input  logic                     rstN,
	// Register bus
	input  logic [pBusAdrsBit-1:0]   csrAdrs,
	input  logic [31:0]              csrWd,
	input  logic                     csrWe,
	input  logic                     csrRe,
	output logic [31:0]              csrRd,
	output logic                     csrRdValid,
	// Memory read bus
	output logic [pMemAdrsWidth-1:0] memAdrs,
	output logic                     memReq,
	input  logic                     memRdy,
	input  logic [cPixelBits-1:0]    memRd,
	input  logic                     memRdValid,
	// Panel
	output tOut                      tftR,
	output tOut                      tftG,
	output tOut                      tftB,
	output logic                     tftHSync,
	output logic                     tftVSync,
	output logic                     tftDe
);

logic                     displayEn;
logic                     dmaEn;
logic [pMemAdrsWidth-1:0] fbufAdrs;
logic                     frameStart;
logic                     pop;
logic                     lineStart;
tSample                   laneData [cChannels];
logic                     laneValid;
logic [cChannels-1:0]     credit;
logic [cChannels-1:0]     underrun;
tOut                      laneOut [cChannels];

videoTxCsr #(
	.pBusAdrsBit   (pBusAdrsBit),
	.pMemAdrsWidth (pMemAdrsWidth)
) csr0 (
	.sysClk     (sysClk),
	.rstN       (rstN),
	.csrAdrs    (csrAdrs),
	.csrWd      (csrWd),
	.csrWe      (csrWe),
	.csrRe      (csrRe),
	.csrRd      (csrRd),
	.csrRdValid (csrRdValid),
	.displayEn  (displayEn),
	.dmaEn      (dmaEn),
	.fbufAdrs   (fbufAdrs),
	.underrun   (underrun),
	.frameStart (frameStart)
);

frameFetcher #(
	.pHdisplay     (pHdisplay),
	.pVdisplay     (pVdisplay),
	.pMemAdrsWidth (pMemAdrsWidth),
	.pLaneDepth    (pLaneDepth)
) fetch0 (
	.sysClk     (sysClk),
	.rstN       (rstN),
	.dmaEn      (dmaEn),
	.frameStart (frameStart),
	.fbufAdrs   (fbufAdrs),
	.memAdrs    (memAdrs),
	.memReq     (memReq),
	.memRdy     (memRdy),
	.memRd      (memRd),
	.memRdValid (memRdValid),
	.laneData   (laneData),
	.laneValid  (laneValid),
	.credit     (credit)
);

//--------------------------------------------------------------------------
// Colour lanes, 0 to 2 are R, G, B
//--------------------------------------------------------------------------
for (genvar i = 0; i < cChannels; i++)
begin : genLane
	colorLane #(
		.pLaneDepth (pLaneDepth)
	) lane (
		.sysClk    (sysClk),
		.rstN      (rstN),
		.pushData  (laneData[i]),
		.push      (laneValid),
		.pop       (pop),
		.lineStart (lineStart),
		.credit    (credit[i]),
		.outValue  (laneOut[i]),
		.underrun  (underrun[i])
	);
end

assign tftR = laneOut[0];
assign tftG = laneOut[1];
assign tftB = laneOut[2];

tftTiming #(
	.pHdisplay (pHdisplay),
	.pHfront   (pHfront),
	.pHpulse   (pHpulse),
	.pHback    (pHback),
	.pVdisplay (pVdisplay),
	.pVfront   (pVfront),
	.pVpulse   (pVpulse),
	.pVback    (pVback)
) timing0 (
	.sysClk     (sysClk),
	.rstN       (rstN),
	.displayEn  (displayEn),
	.pop        (pop),
	.lineStart  (lineStart),
	.frameStart (frameStart),
	.tftHSync   (tftHSync),
	.tftVSync   (tftVSync),
	.tftDe      (tftDe)
);

endmodule

// File: dv/videoTx_assert.sv
//--------------------------------------------------------------------------
// Frame fetcher assertions
// Credit bounds and memory request rules for frameFetcher
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module videoTxAssert
	import videoTxPkg::*;
#(
	parameter int pMemAdrsWidth = 19,
	parameter int pLaneDepth    = 8,
	parameter int cCreditW      = $clog2(pLaneDepth + 1)
)(
	input logic                     sysClk,
	input logic                     rstN,
	input logic                     memReq,
	input logic                     memRdy,
	input logic [pMemAdrsWidth-1:0] memAdrs,
	input logic [cCreditW-1:0]      creditCnt [cChannels]
);

logic anyZero;

always_comb
begin
	anyZero = 1'b0;
	for (int i = 0; i < cChannels; i++)
	begin
		if (creditCnt[i] == '0)
			anyZero = 1'b1;
	end
end

for (genvar i = 0; i < cChannels; i++)
begin : genCredit
	aCreditMax: assert property (@(posedge sysClk) disable iff (!rstN)
		creditCnt[i] <= cCreditW'(pLaneDepth))
		else $error("credit counter above lane depth");
end

// Stalled request holds address and strobe
aReqStable: assert property (@(posedge sysClk) disable iff (!rstN)
	memReq && !memRdy |=> memReq && $stable(memAdrs))
	else $error("memory request changed while stalled");

// Every new request needs a credit in each lane
aReqCredit: assert property (@(posedge sysClk) disable iff (!rstN)
	memReq && !$past(memReq && !memRdy) |-> !anyZero)
	else $error("memory request raised with a zero credit counter");

endmodule

bind frameFetcher videoTxAssert #(
	.pMemAdrsWidth (pMemAdrsWidth),
	.pLaneDepth    (pLaneDepth)
) assert0 (
	.sysClk    (sysClk),
	.rstN      (rstN),
	.memReq    (memReq),
	.memRdy    (memRdy),
	.memAdrs   (memAdrs),
	.creditCnt (creditCnt)
);

// File: dv/videoTxTb.sv
//--------------------------------------------------------------------------
// Video transmit testbench
// CSR access, stalling memory model, sync timing monitor and a
// pixel compare against a dithering reference
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module videoTxTb;

localparam int cHdisp  = 16;
localparam int cHfront = 2;
localparam int cHpulse = 3;
localparam int cHback  = 4;
localparam int cVdisp  = 4;
localparam int cVfront = 1;
localparam int cVpulse = 2;
localparam int cVback  = 2;
localparam int cLine   = cHdisp + cHfront + cHpulse + cHback;
localparam int cFrame  = cHdisp * cVdisp;
localparam int cMemSize = 1024;
localparam int cBaseA  = 'h040;
localparam int cBaseB  = 'h200;

logic        sysClk;
logic        rstN;
logic [15:0] csrAdrs;
logic [31:0] csrWd;
logic        csrWe;
logic        csrRe;
logic [31:0] csrRd;
logic        csrRdValid;
logic [18:0] memAdrs;
logic        memReq;
logic        memRdy;
logic [15:0] memRd;
logic        memRdValid;
logic [3:0]  tftR;
logic [3:0]  tftG;
logic [3:0]  tftB;
logic        tftHSync;
logic        tftVSync;
logic        tftDe;

logic [15:0] memModel [cMemSize];
logic [31:0] lcgState;
logic [15:0] rdQ [$];
int          dueQ [$];
int          stallOn;
int          cmpMode;
int          pixCount;
int          monOn;
int          hRun;
int          deRun;
int          vRun;
int          deLines;
int          vFalls;
logic        prevH;
logic        prevV;
logic        prevDe;
logic [3:0]  resid [3];

videoTxTop #(
	.pHdisplay  (cHdisp),
	.pHfront    (cHfront),
	.pHpulse    (cHpulse),
	.pHback     (cHback),
	.pVdisplay  (cVdisp),
	.pVfront    (cVfront),
	.pVpulse    (cVpulse),
	.pVback     (cVback),
	.pLaneDepth (8)
) dut0 (
	.sysClk     (sysClk),
	.rstN       (rstN),
	.csrAdrs    (csrAdrs),
	.csrWd      (csrWd),
	.csrWe      (csrWe),
	.csrRe      (csrRe),
	.csrRd      (csrRd),
	.csrRdValid (csrRdValid),
	.memAdrs    (memAdrs),
	.memReq     (memReq),
	.memRdy     (memRdy),
	.memRd      (memRd),
	.memRdValid (memRdValid),
	.tftR       (tftR),
	.tftG       (tftG),
	.tftB       (tftB),
	.tftHSync   (tftHSync),
	.tftVSync   (tftVSync),
	.tftDe      (tftDe)
);

always #4 sysClk = ~sysClk;

function automatic logic [31:0] lcgNext(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

// Expand and dither one channel of an RGB565 word
// Result holds the output in the upper and the residual in the lower nibble
function automatic logic [7:0] refPixel(input logic [15:0] word, input int ch,
	input logic [3:0] res);
	logic [7:0] sample;
	logic [8:0] sum;
	case (ch)
		0: sample = {word[15:11], word[15:13]};
		1: sample = {word[10:5], word[10:9]};
		default: sample = {word[4:0], word[4:2]};
	endcase
	sum = {1'b0, sample} + {5'b0, res};
	if (sum > 9'd255)
		return 8'hF0;
	return sum[7:0];
endfunction

task automatic failRun(input string msg);
	$display("ERROR: %s", msg);
	$display("Simulation FAILED");
	$fatal(1, "run aborted");
endtask

task automatic checkEq(input string name, input int expected, input int actual);
	if (expected != actual)
	begin
		$display("FAILED %s expected %0d actual %0d", name, expected, actual);
		$display("Simulation FAILED");
		$fatal(1, "value mismatch");
	end
endtask

task automatic csrWrite(input int adrs, input logic [31:0] data);
	@(posedge sysClk);
	#1;
	csrAdrs = 16'(adrs);
	csrWd   = data;
	csrWe   = 1'b1;
	@(posedge sysClk);
	#1;
	csrWe   = 1'b0;
endtask

task automatic csrRead(input int adrs, output logic [31:0] data);
	@(posedge sysClk);
	#1;
	csrAdrs = 16'(adrs);
	csrRe   = 1'b1;
	@(posedge sysClk);
	#1;
	csrRe   = 1'b0;
	checkEq("csrRdValid one cycle after csrRe", 1, int'(csrRdValid));
	data    = csrRd;
endtask

//--------------------------------------------------------------------------
// Memory model with in-order returns after 1 to 3 cycles
//--------------------------------------------------------------------------
initial
begin
	int          cyc;
	int          lat;
	int          due;
	int          lastDue;
	logic        acc;
	logic [18:0] adr;
	cyc     = 0;
	lastDue = 0;
	@(posedge rstN);
	forever
	begin
		@(negedge sysClk);
		acc = memReq && memRdy;
		adr = memAdrs;
		@(posedge sysClk);
		cyc++;
		if (acc)
		begin
			if (adr >= 19'(cMemSize))
				failRun("memory address outside the model");
			lcgState = lcgNext(lcgState);
			lat = 1 + int'(lcgState[15:8]) % 3;
			due = cyc - 1 + lat;
			if (due <= lastDue)
				due = lastDue + 1;
			lastDue = due;
			rdQ.push_back(memModel[adr[9:0]]);
			dueQ.push_back(due);
		end
		#1;
		memRdValid = 1'b0;
		if (dueQ.size() > 0 && dueQ[0] == cyc)
		begin
			memRd      = rdQ.pop_front();
			memRdValid = 1'b1;
			void'(dueQ.pop_front());
		end
		// Stalls only in blanking, so the lanes keep up in the active area
		lcgState = lcgNext(lcgState);
		memRdy = !(stallOn != 0 && !tftDe && lcgState[31:30] == 2'b00);
	end
end

//--------------------------------------------------------------------------
// Pixel compare
//--------------------------------------------------------------------------
always @(negedge sysClk)
begin
	int          idx;
	int          base;
	logic [15:0] word;
	logic [7:0]  res;
	logic [3:0]  act;
	if (tftDe && cmpMode == 1)
	begin
		checkEq("blank pixel R", 0, int'(tftR));
		checkEq("blank pixel G", 0, int'(tftG));
		checkEq("blank pixel B", 0, int'(tftB));
	end
	else if (tftDe && cmpMode == 2 && pixCount < 2 * cFrame)
	begin
		idx  = pixCount % cFrame;
		base = (pixCount < cFrame) ? cBaseA : cBaseB;
		word = memModel[(base + idx) % cMemSize];
		for (int ch = 0; ch < 3; ch++)
		begin
			res = refPixel(word, ch, (idx % cHdisp == 0) ? 4'h0 : resid[ch]);
			resid[ch] = res[3:0];
			act = (ch == 0) ? tftR : (ch == 1) ? tftG : tftB;
			checkEq($sformatf("pixel %0d channel %0d", pixCount, ch),
				int'(res[7:4]), int'(act));
		end
		pixCount++;
	end
end

//--------------------------------------------------------------------------
// Sync and enable timing monitor
//--------------------------------------------------------------------------
always @(negedge sysClk)
begin
	if (monOn != 0)
	begin
		if (!tftHSync)
			hRun++;
		else if (!prevH)
		begin
			checkEq("hSync low width", cHpulse, hRun);
			hRun = 0;
		end
		if (tftDe)
			deRun++;
		else if (prevDe)
		begin
			checkEq("tftDe width", cHdisp, deRun);
			deRun = 0;
			deLines++;
		end
		if (!tftVSync)
			vRun++;
		else if (!prevV)
		begin
			checkEq("vSync low cycles", cVpulse * cLine, vRun);
			vRun = 0;
		end
		if (prevV && !tftVSync)
		begin
			if (vFalls > 0)
				checkEq("active lines per frame", cVdisp, deLines);
			deLines = 0;
			vFalls++;
		end
		prevH  = tftHSync;
		prevV  = tftVSync;
		prevDe = tftDe;
	end
end

initial
begin
	#1000000;
	failRun("global simulation timeout");
end

//--------------------------------------------------------------------------
// Test sequence
//--------------------------------------------------------------------------
initial
begin
	logic [31:0] rd;
	int          n;
	sysClk     = 1'b0;
	rstN       = 1'b0;
	csrAdrs    = '0;
	csrWd      = '0;
	csrWe      = 1'b0;
	csrRe      = 1'b0;
	memRdy     = 1'b1;
	memRd      = '0;
	memRdValid = 1'b0;
	stallOn    = 0;
	cmpMode    = 0;
	pixCount   = 0;
	monOn      = 0;
	lcgState   = 32'h28c647ec;
	for (int i = 0; i < cMemSize; i++)
	begin
		lcgState    = lcgNext(lcgState);
		memModel[i] = lcgState[31:16];
	end

	repeat (10) @(posedge sysClk);
	#1;
	rstN = 1'b1;

	// Reset state
	checkEq("reset tftDe", 0, int'(tftDe));
	checkEq("reset tftHSync", 1, int'(tftHSync));
	checkEq("reset tftVSync", 1, int'(tftVSync));
	checkEq("reset csrRdValid", 0, int'(csrRdValid));
	checkEq("reset memReq", 0, int'(memReq));
	csrRead('h0, rd);
	checkEq("reset CTRL", 0, int'(rd));
	csrRead('h4, rd);
	checkEq("reset FBUF", 0, int'(rd));
	csrRead('h8, rd);
	checkEq("reset STATUS", 0, int'(rd));

	// Register readback with the display off
	csrWrite('h0, 32'hFFFF_FFFE);
	csrRead('h0, rd);
	checkEq("CTRL readback", 2, int'(rd));
	csrWrite('h0, 32'h0);
	csrWrite('h4, 32'hFFFF_FFFF);
	csrRead('h4, rd);
	checkEq("FBUF readback", 'h7FFFF, int'(rd));
	csrWrite('h8, 32'hFFFF_FFFF);
	csrRead('h8, rd);
	checkEq("STATUS readback", 0, int'(rd));

	// Display without DMA for timing, blank pixels, underflow and frame count
	hRun    = 0;
	deRun   = 0;
	vRun    = 0;
	deLines = 0;
	vFalls  = 0;
	prevH   = 1'b1;
	prevV   = 1'b1;
	prevDe  = 1'b0;
	monOn   = 1;
	cmpMode = 1;
	csrWrite('h0, 32'h1);
	n = 0;
	while (vFalls < 3)
	begin
		@(posedge sysClk);
		n++;
		if (n > 4 * cLine * 9)
			failRun("vSync did not fall three times");
	end
	n = 0;
	while (!tftDe)
	begin
		@(posedge sysClk);
		n++;
		if (n > 2 * cLine * 9)
			failRun("no active pixel after the third frame start");
	end
	monOn = 0;
	csrWrite('h0, 32'h0);
	cmpMode = 0;
	csrRead('h8, rd);
	checkEq("STATUS underflow set", 1, int'(rd[0]));
	checkEq("STATUS frame count", vFalls % 256, int'(rd[15:8]));
	csrWrite('h8, 32'h1);
	csrRead('h8, rd);
	checkEq("STATUS after clear", (vFalls % 256) * 256, int'(rd));

	// DMA with stalls over two frames and a base moved mid-frame
	csrWrite('h4, 32'(cBaseA));
	stallOn  = 1;
	pixCount = 0;
	cmpMode  = 2;
	csrWrite('h0, 32'h3);
	n = 0;
	while (pixCount < 24)
	begin
		@(posedge sysClk);
		n++;
		if (n > 2 * cLine * 9)
			failRun("first frame pixels did not appear");
	end
	csrWrite('h4, 32'(cBaseB));
	n = 0;
	while (pixCount < 2 * cFrame)
	begin
		@(posedge sysClk);
		n++;
		if (n > 3 * cLine * 9)
			failRun("second frame did not complete");
	end
	cmpMode = 0;
	csrWrite('h0, 32'h0);
	stallOn = 0;
	csrRead('h8, rd);
	checkEq("STATUS underflow with DMA", 0, int'(rd[0]));

	repeat (4) @(posedge sysClk);
	$display("Simulation PASSED");
	$finish;
end

endmodule

// File: files.f
src/videoTxPkg.sv
src/videoTxCsr.sv
src/frameFetcher.sv
src/colorLane.sv
src/tftTiming.sv
src/videoTxTop.sv
dv/videoTx_assert.sv
dv/videoTxTb.sv

// File: run.sh
#!/bin/sh
# Build and run the video transmit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing -j 0 --top-module videoTxTb -f files.f \
	--Mdir obj_dir -o simv > build.log 2>&1 \
	&& ./obj_dir/simv > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0
